//--- src/cfg_bridge_pkg.sv
// Shared widths, config-bus addresses and types; assumes the 4-bit/32-bit hard IP config bus and 64-bit Avalon reads
package cfg_bridge_pkg;

   // Widths and counts
   localparam int CFG_ADDR_W    = 4;
   localparam int CFG_DATA_W    = 32;
   localparam int RXM_DATA_W    = 64;
   localparam int BUS_DEV_W     = 13;
   localparam int MSI_ADDR_W    = 64;
   localparam int MSI_DATA_W    = 16;
   localparam int MAX_RXM_PORTS = 6;

   // Configuration bus addresses, anything else is ignored
   localparam logic [CFG_ADDR_W-1:0] CFG_A_DEVCSR     = 4'h0;
   localparam logic [CFG_ADDR_W-1:0] CFG_A_PRMCSR     = 4'h3;
   localparam logic [CFG_ADDR_W-1:0] CFG_A_MSI_ADDR_0 = 4'h5;  // MSI addr 11:0
   localparam logic [CFG_ADDR_W-1:0] CFG_A_MSI_ADDR_2 = 4'h6;  // MSI addr 43:32
   localparam logic [CFG_ADDR_W-1:0] CFG_A_MSI_ADDR_1 = 4'h9;  // MSI addr 31:12
   localparam logic [CFG_ADDR_W-1:0] CFG_A_MSI_ADDR_3 = 4'hB;  // MSI addr 63:44
   localparam logic [CFG_ADDR_W-1:0] CFG_A_MSI_CTL    = 4'hD;
   localparam logic [CFG_ADDR_W-1:0] CFG_A_BUSDEV     = 4'hF;  // Also carries MSI data

   // Halves view of a config word
   typedef struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
   } cfg_halves_t;

   // Command register sits in the middle of the word
   typedef struct packed {
      logic [7:0]  top;
      logic [15:0] cmd;
      logic [7:0]  low;
   } cfg_mid_t;

   typedef union packed {
      cfg_halves_t split;
      cfg_mid_t    mid;
   } cfg_halves_u;

   // Fragment view used by the MSI address pieces
   typedef struct packed {
      logic [19:0] upper;  // 20-bit fragment
      logic [11:0] lower;
   } cfg_frag_t;

   typedef struct packed {
      logic [11:0] top;    // 12-bit fragment
      logic [19:0] rest;
   } cfg_top_t;

   typedef union packed {
      cfg_frag_t split;
      cfg_top_t  top;
   } cfg_frag_u;

   // One config data word, decoded as halves or as address fragments
   typedef union packed {
      cfg_halves_u halves;
      cfg_frag_u   frag;
   } cfg_word_u;

   // Shadow copy of the config space fields the bridge cares about
   typedef struct packed {
      logic [BUS_DEV_W-1:0]  bus_dev;
      logic [CFG_DATA_W-1:0] dev_csr;
      logic [15:0]           prm_csr;
      logic [15:0]           msi_en;
      logic [15:0]           msix_ctl;
      logic [MSI_ADDR_W-1:0] msi_addr;
      logic [MSI_DATA_W-1:0] msi_data;
   } cfg_shadow_t;

   // MSI interface word, 82 bits
   typedef struct packed {
      logic                  master_en;  // Command bit 2
      logic                  msi_en;     // MSI enable bit 0
      logic [MSI_DATA_W-1:0] msi_data;
      logic [MSI_ADDR_W-1:0] msi_addr;
   } msi_intfc_t;

   // Read response of one Avalon master port
   typedef struct packed {
      logic                  wait_req;
      logic                  valid;
      logic [RXM_DATA_W-1:0] data;
   } rxm_rsp_t;

endpackage

//--- src/cfg_shadow.sv
// Config bus is sampled every cycle with no strobe; a held word rewrites the same value, unknown addresses are dropped
`timescale 1ns/1ps

module cfg_shadow
(
   input  logic                                   AvlClk_i,
   input  logic                                   Rstn_i,
   input  logic [cfg_bridge_pkg::CFG_ADDR_W-1:0]  cfg_addr_i,
   input  cfg_bridge_pkg::cfg_word_u              cfg_data_i,
   output logic                                   rst_sync_n_o,
   output cfg_bridge_pkg::cfg_shadow_t            shadow_o
);

   import cfg_bridge_pkg::*;

   logic                  rst_meta_n;
   logic                  rst_sync_n;
   logic [CFG_ADDR_W-1:0] cfg_addr_q;
   cfg_word_u             cfg_data_q;

   // Reset asserts at once, releases after two clock edges
   always_ff @(posedge AvlClk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         rst_meta_n <= 1'b0;
         rst_sync_n <= 1'b0;
      end
      else
      begin
         rst_meta_n <= 1'b1;
         rst_sync_n <= rst_meta_n;
      end
   end

   assign rst_sync_n_o = rst_sync_n;

   // Input pipeline for the config bus
   always_ff @(posedge AvlClk_i or negedge rst_sync_n)
   begin
      if (!rst_sync_n)
      begin
         cfg_addr_q <= '0;
         cfg_data_q <= '0;
      end
      else
      begin
         cfg_addr_q <= cfg_addr_i;
         cfg_data_q <= cfg_data_i;
      end
   end

   // Address decode into the shadow fields
   // Each field keeps its value unless its own address shows up
   always_ff @(posedge AvlClk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         shadow_o <= '0;
      end
      else
      begin
         case (cfg_addr_q)
            CFG_A_DEVCSR:
            begin
               // Status/control sit in the upper half
               shadow_o.dev_csr <= {16'h0, cfg_data_q.halves.split.hi};
            end
            CFG_A_PRMCSR:
            begin
               shadow_o.prm_csr <= cfg_data_q.halves.mid.cmd;
            end
            CFG_A_MSI_ADDR_0:
            begin
               shadow_o.msi_addr[11:0] <= cfg_data_q.frag.top.top;
            end
            CFG_A_MSI_ADDR_1:
            begin
               shadow_o.msi_addr[31:12] <= cfg_data_q.frag.split.upper;
            end
            CFG_A_MSI_ADDR_2:
            begin
               shadow_o.msi_addr[43:32] <= cfg_data_q.frag.top.top;
            end
            CFG_A_MSI_ADDR_3:
            begin
               shadow_o.msi_addr[63:44] <= cfg_data_q.frag.split.upper;
            end
            CFG_A_MSI_CTL:
            begin
               shadow_o.msi_en   <= cfg_data_q.halves.split.lo;
               shadow_o.msix_ctl <= cfg_data_q.halves.split.hi;  // MSI-X control in upper half
            end
            CFG_A_BUSDEV:
            begin
               // Bus/device and MSI data share this word
               shadow_o.bus_dev  <= cfg_data_q.halves.split.lo[BUS_DEV_W-1:0];
               shadow_o.msi_data <= cfg_data_q.halves.split.hi;
            end
            default:
            begin
               shadow_o <= shadow_o;  // Unused address
            end
         endcase
      end
   end

endmodule

//--- src/msi_cfg_out.sv
// One register stage on the synchronized reset; outputs read zero until the first config words land
`timescale 1ns/1ps

module msi_cfg_out
(
   input  logic                                  AvlClk_i,
   input  logic                                  rst_sync_n_i,
   input  cfg_bridge_pkg::cfg_shadow_t           shadow_i,
   output cfg_bridge_pkg::msi_intfc_t            msi_intfc_o,
   output logic [15:0]                           msi_control_o,
   output logic [15:0]                           msix_intfc_o,
   output logic [cfg_bridge_pkg::CFG_DATA_W-1:0] dev_csr_o,
   output logic [cfg_bridge_pkg::BUS_DEV_W-1:0]  bus_dev_o
);

   import cfg_bridge_pkg::*;

   msi_intfc_t msi_word;

   // Pack the MSI interface word from the shadow set
   always_comb
   begin
      msi_word.master_en = shadow_i.prm_csr[2];  // Bus master enable
      msi_word.msi_en    = shadow_i.msi_en[0];
      msi_word.msi_data  = shadow_i.msi_data;
      msi_word.msi_addr  = shadow_i.msi_addr;
   end

   // Output registers
   always_ff @(posedge AvlClk_i or negedge rst_sync_n_i)
   begin
      if (!rst_sync_n_i)
      begin
         msi_intfc_o   <= '0;
         msi_control_o <= '0;
         msix_intfc_o  <= '0;
         dev_csr_o     <= '0;
         bus_dev_o     <= '0;
      end
      else
      begin
         msi_intfc_o   <= msi_word;
         msi_control_o <= shadow_i.msi_en;    // Full MSI enable field
         msix_intfc_o  <= shadow_i.msix_ctl;
         dev_csr_o     <= shadow_i.dev_csr;
         bus_dev_o     <= shadow_i.bus_dev;
      end
   end

endmodule

//--- src/rxm_rdata_mux.sv
// Combinational merge with no back-pressure; colliding valids return zero data, disabled ports never win
`timescale 1ns/1ps

module rxm_rdata_mux
#(
   parameter int unsigned                 NUM_RXM_PORTS = cfg_bridge_pkg::MAX_RXM_PORTS,
   parameter logic [NUM_RXM_PORTS-1:0]    RXM_PORT_EN   = '1
)
(
   input  cfg_bridge_pkg::rxm_rsp_t [NUM_RXM_PORTS-1:0] rxm_rsp_i,
   output logic [NUM_RXM_PORTS-1:0]                     rxm_wait_o,
   output logic                                         rd_valid_o,
   output logic [cfg_bridge_pkg::RXM_DATA_W-1:0]        rd_data_o
);

   import cfg_bridge_pkg::*;

   logic [MAX_RXM_PORTS-1:0] valid_vec;
   logic [MAX_RXM_PORTS-1:0] wait_vec;
   logic [RXM_DATA_W-1:0]    data_arr [MAX_RXM_PORTS];
   logic                     valid_onehot;

   // Tie off ports that are disabled or not built
   for (genvar i = 0; i < MAX_RXM_PORTS; i++)
   begin : g_port
      if (i < NUM_RXM_PORTS)
      begin : g_built
         if (RXM_PORT_EN[i])
         begin : g_on
            assign valid_vec[i] = rxm_rsp_i[i].valid;
            assign wait_vec[i]  = rxm_rsp_i[i].wait_req;
            assign data_arr[i]  = rxm_rsp_i[i].data;
         end
         else
         begin : g_off
            assign valid_vec[i] = 1'b0;
            assign wait_vec[i]  = 1'b1;  // Stall anything aimed at a dead port
            assign data_arr[i]  = '0;
         end
      end
      else
      begin : g_absent
         assign valid_vec[i] = 1'b0;
         assign wait_vec[i]  = 1'b1;
         assign data_arr[i]  = '0;
      end
   end

   assign rxm_wait_o   = wait_vec[NUM_RXM_PORTS-1:0];
   assign rd_valid_o   = |valid_vec;
   assign valid_onehot = (valid_vec != '0) && ((valid_vec & (valid_vec - 1'b1)) == '0);

   // One-hot select, zero otherwise
   always_comb
   begin
      rd_data_o = '0;
      if (valid_onehot)
      begin
         for (int p = 0; p < MAX_RXM_PORTS; p++)
         begin
            if (valid_vec[p])
            begin
               rd_data_o = data_arr[p];
            end
         end
      end
   end

endmodule

//--- src/pcie_cfg_bridge.sv
// Config path and read-return mux are independent; config outputs lag the bus by three clocks, reads by none
`timescale 1ns/1ps

module pcie_cfg_bridge
#(
   parameter int unsigned              NUM_RXM_PORTS = cfg_bridge_pkg::MAX_RXM_PORTS,
   parameter logic [NUM_RXM_PORTS-1:0] RXM_PORT_EN   = '1  // Set a bit for each port with a BAR
)
(
   input  logic                                         AvlClk_i,
   input  logic                                         Rstn_i,

   // Config bus from the hard IP
   input  logic [cfg_bridge_pkg::CFG_ADDR_W-1:0]        cfg_addr_i,
   input  logic [cfg_bridge_pkg::CFG_DATA_W-1:0]        cfg_data_i,

   // Avalon master read returns
   input  cfg_bridge_pkg::rxm_rsp_t [NUM_RXM_PORTS-1:0] rxm_rsp_i,
   output logic [NUM_RXM_PORTS-1:0]                     rxm_wait_o,
   output logic                                         txs_rd_valid_o,
   output logic [cfg_bridge_pkg::RXM_DATA_W-1:0]        txs_rd_data_o,

   // Config outputs
   output cfg_bridge_pkg::msi_intfc_t                   msi_intfc_o,
   output logic [15:0]                                  msi_control_o,
   output logic [15:0]                                  msix_intfc_o,
   output logic [cfg_bridge_pkg::CFG_DATA_W-1:0]        dev_csr_o,
   output logic [cfg_bridge_pkg::BUS_DEV_W-1:0]         bus_dev_o
);

   import cfg_bridge_pkg::*;

   logic        rst_sync_n;
   cfg_shadow_t shadow;

   // Capture and decode of the config stream
   cfg_shadow u_cfg_shadow
   (
      .AvlClk_i     (AvlClk_i),
      .Rstn_i       (Rstn_i),
      .cfg_addr_i   (cfg_addr_i),
      .cfg_data_i   (cfg_data_i),
      .rst_sync_n_o (rst_sync_n),
      .shadow_o     (shadow)
   );

   // Registered config outputs
   msi_cfg_out u_msi_cfg_out
   (
      .AvlClk_i      (AvlClk_i),
      .rst_sync_n_i  (rst_sync_n),
      .shadow_i      (shadow),
      .msi_intfc_o   (msi_intfc_o),
      .msi_control_o (msi_control_o),
      .msix_intfc_o  (msix_intfc_o),
      .dev_csr_o     (dev_csr_o),
      .bus_dev_o     (bus_dev_o)
   );

   // Read data back toward the TX slave
   rxm_rdata_mux
   #(
      .NUM_RXM_PORTS (NUM_RXM_PORTS),
      .RXM_PORT_EN   (RXM_PORT_EN)
   )
   u_rxm_rdata_mux
   (
      .rxm_rsp_i  (rxm_rsp_i),
      .rxm_wait_o (rxm_wait_o),
      .rd_valid_o (txs_rd_valid_o),
      .rd_data_o  (txs_rd_data_o)
   );

endmodule

//--- verif/tb_ref_model.svh
// Included inside the testbench module after its signals; expects cfg_bridge_pkg imported and lfsr_state, n_checks declared
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Expected read-return outputs for one cycle
typedef struct packed {
   logic                     valid;
   logic [RXM_DATA_W-1:0]    data;
   logic [MAX_RXM_PORTS-1:0] wait_req;
} mux_exp_t;

// Config decode table applied to the model state
function automatic cfg_shadow_t apply_cfg_word(input cfg_shadow_t s,
                                               input logic [CFG_ADDR_W-1:0] addr,
                                               input logic [CFG_DATA_W-1:0] d);
   cfg_shadow_t n;
   n = s;
   case (addr)
      CFG_A_DEVCSR:     n.dev_csr         = {16'h0, d[31:16]};
      CFG_A_PRMCSR:     n.prm_csr         = d[23:8];
      CFG_A_MSI_ADDR_0: n.msi_addr[11:0]  = d[31:20];
      CFG_A_MSI_ADDR_2: n.msi_addr[43:32] = d[31:20];
      CFG_A_MSI_ADDR_1: n.msi_addr[31:12] = d[31:12];
      CFG_A_MSI_ADDR_3: n.msi_addr[63:44] = d[31:12];
      CFG_A_MSI_CTL:
      begin
         n.msi_en   = d[15:0];
         n.msix_ctl = d[31:16];
      end
      CFG_A_BUSDEV:
      begin
         n.bus_dev  = d[12:0];
         n.msi_data = d[31:16];  // Same word as bus/device
      end
      default:          n = s;   // Unused address
   endcase
   return n;
endfunction

// MSI word from MSB: master enable, MSI enable, data, address
function automatic msi_intfc_t expected_msi_word(input cfg_shadow_t s);
   return {s.prm_csr[2], s.msi_en[0], s.msi_data, s.msi_addr};
endfunction

function automatic mux_exp_t expected_mux(input rxm_rsp_t [MAX_RXM_PORTS-1:0] rsp,
                                          input logic [MAX_RXM_PORTS-1:0] en);
   mux_exp_t e;
   int       hits;
   e    = '0;
   hits = 0;
   for (int p = 0; p < MAX_RXM_PORTS; p++)
   begin
      if (en[p])
      begin
         e.wait_req[p] = rsp[p].wait_req;
         if (rsp[p].valid)
         begin
            hits++;
            e.data = rsp[p].data;
         end
      end
      else
      begin
         e.wait_req[p] = 1'b1;  // Disabled port stalls
      end
   end
   e.valid = (hits > 0);
   if (hits != 1)
   begin
      e.data = '0;  // Nothing valid or a collision
   end
   return e;
endfunction

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   logic fb;
   fb = s[31] ^ s[21] ^ s[1] ^ s[0];
   return {s[30:0], fb};
endfunction

// One LFSR step per bit taken
function automatic logic [63:0] rand_bits(input int n);
   logic [63:0] r;
   r = '0;
   for (int i = 0; i < n; i++)
   begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
   end
   return r;
endfunction

task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                           input string what);
   n_checks++;
   if (got !== exp)
   begin
      $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "%s mismatch", what);
   end
endtask

`endif

//--- verif/tb_pcie_cfg_bridge.sv
// Runs under Verilator with --timing; ports 2, 3 and 5 are built disabled and random data comes from a fixed LFSR seed
`timescale 1ns/1ps

module tb_pcie_cfg_bridge;

   import cfg_bridge_pkg::*;

   localparam int                    NUM_PORTS      = 6;
   localparam logic [NUM_PORTS-1:0]  PORT_EN        = 6'b010011;
   localparam logic [CFG_ADDR_W-1:0] IDLE_ADDR      = 4'h1;
   localparam int                    ADDR_WORDS     = 6;
   localparam int                    UNUSED_WORDS   = 4;
   localparam int                    MIXED_STEPS    = 64;
   localparam int                    ONEHOT_STEPS   = 40;
   localparam int                    COLLIDE_STEPS  = 60;
   localparam int                    STIM_CYCLES    = 8 + 8 * ADDR_WORDS + 6 + 8 * UNUSED_WORDS
                                                      + MIXED_STEPS + ONEHOT_STEPS + COLLIDE_STEPS
                                                      + 3 + 6;
   localparam logic [CFG_ADDR_W-1:0] USED_ADDR [8]  = '{CFG_A_DEVCSR, CFG_A_PRMCSR,
                                                        CFG_A_MSI_ADDR_0, CFG_A_MSI_ADDR_2,
                                                        CFG_A_MSI_ADDR_1, CFG_A_MSI_ADDR_3,
                                                        CFG_A_MSI_CTL, CFG_A_BUSDEV};
   localparam logic [CFG_ADDR_W-1:0] UNUSED_ADDR [8] = '{4'h1, 4'h2, 4'h4, 4'h7,
                                                         4'h8, 4'hA, 4'hC, 4'hE};
   localparam int                    EN_PORTS [3]   = '{0, 1, 4};

   logic                     avl_clk;
   logic                     rstn;
   logic [CFG_ADDR_W-1:0]    cfg_addr;
   cfg_word_u                cfg_data;
   rxm_rsp_t [NUM_PORTS-1:0] rxm_rsp;
   logic [NUM_PORTS-1:0]     rxm_wait;
   logic                     rd_valid;
   logic [RXM_DATA_W-1:0]    rd_data;
   msi_intfc_t               msi_intfc;
   logic [15:0]              msi_control;
   logic [15:0]              msix_intfc;
   logic [CFG_DATA_W-1:0]    dev_csr;
   logic [BUS_DEV_W-1:0]     bus_dev;
   logic [31:0]              lfsr_state;
   int                       n_checks;
   cfg_shadow_t              model;
   cfg_shadow_t              hist [$];  // Model state per edge with the oldest first

   `include "tb_ref_model.svh"

   pcie_cfg_bridge
   #(
      .NUM_RXM_PORTS (NUM_PORTS),
      .RXM_PORT_EN   (PORT_EN)
   )
   u_pcie_cfg_bridge
   (
      .AvlClk_i       (avl_clk),
      .Rstn_i         (rstn),
      .cfg_addr_i     (cfg_addr),
      .cfg_data_i     (cfg_data),
      .rxm_rsp_i      (rxm_rsp),
      .rxm_wait_o     (rxm_wait),
      .txs_rd_valid_o (rd_valid),
      .txs_rd_data_o  (rd_data),
      .msi_intfc_o    (msi_intfc),
      .msi_control_o  (msi_control),
      .msix_intfc_o   (msix_intfc),
      .dev_csr_o      (dev_csr),
      .bus_dev_o      (bus_dev)
   );

   always #5 avl_clk = ~avl_clk;

   // One clock of stimulus with a config word and fresh read responses
   task automatic step(input logic [CFG_ADDR_W-1:0] addr, input logic [CFG_DATA_W-1:0] data,
                       input logic [NUM_PORTS-1:0] valid_vec);
      rxm_rsp_t [NUM_PORTS-1:0] rsp;
      @(posedge avl_clk);
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         rsp[p].wait_req = (rand_bits(1) != 0);
         rsp[p].valid    = valid_vec[p];
         rsp[p].data     = rand_bits(64);
      end
      rxm_rsp  <= rsp;
      cfg_addr <= addr;
      cfg_data <= data;
   endtask

   initial
   begin
      cfg_word_u word;
      int        idx;
      avl_clk    = 1'b0;
      rstn       = 1'b0;
      cfg_addr   = IDLE_ADDR;
      cfg_data   = '0;
      rxm_rsp    = '0;
      lfsr_state = 32'h5638;
      n_checks   = 0;
      model      = '0;
      repeat (4) @(posedge avl_clk);
      rstn <= 1'b1;
      repeat (4) step(IDLE_ADDR, 32'h0, '0);  // Let the reset synchronizer release
      foreach (USED_ADDR[a])
      begin
         repeat (ADDR_WORDS) step(USED_ADDR[a], 32'(rand_bits(32)), '0);
      end
      // Master enable and MSI enable through a held word
      word = 32'(rand_bits(32));
      word.halves.mid.cmd[2] = 1'b1;
      repeat (3) step(CFG_A_PRMCSR, word, '0);
      word = 32'(rand_bits(32));
      word.halves.split.lo[0] = 1'b1;
      step(CFG_A_MSI_CTL, word, '0);
      word.halves.mid.cmd[2] = 1'b0;
      step(CFG_A_PRMCSR, word, '0);
      step(CFG_A_BUSDEV, 32'(rand_bits(32)), '0);
      foreach (UNUSED_ADDR[a])
      begin
         repeat (UNUSED_WORDS) step(UNUSED_ADDR[a], 32'(rand_bits(32)), '0);
      end
      repeat (MIXED_STEPS) step(4'(rand_bits(4)), 32'(rand_bits(32)), '0);
      // Read returns on a single enabled port
      repeat (ONEHOT_STEPS)
      begin
         idx = int'(rand_bits(2) % 3);
         step(IDLE_ADDR, 32'h0, 6'b1 << EN_PORTS[idx]);
      end
      step(IDLE_ADDR, 32'h0, 6'b000011);
      step(IDLE_ADDR, 32'h0, 6'b010001);
      step(IDLE_ADDR, 32'h0, 6'b101100);  // Disabled ports only
      repeat (COLLIDE_STEPS) step(IDLE_ADDR, 32'h0, 6'(rand_bits(6)));
      repeat (6) step(IDLE_ADDR, 32'h0, '0);  // Drain the config pipeline
      if (n_checks == 0)
      begin
         $display("TB FAILED");
         $fatal(1, "compare process never ran a check");
      end
      else
      begin
         $display("TB PASSED");
         $finish;
      end
   end

   // Config outputs lag three edges while the read mux has no latency
   // Checks run from the first falling edge so the reset values are seen too
   always @(negedge avl_clk)
   begin
      cfg_shadow_t exp_cfg;
      mux_exp_t    exp_mux;
      model = apply_cfg_word(model, cfg_addr, cfg_data);  // Word sampled at the next edge
      hist.push_back(model);
      if (hist.size() > 4)
      begin
         void'(hist.pop_front());
      end
      exp_cfg = hist[0];
      exp_mux = expected_mux(rxm_rsp, PORT_EN);
      check_value(128'(msi_intfc), 128'(expected_msi_word(exp_cfg)), "msi_intfc_o");
      check_value(128'(msi_control), 128'(exp_cfg.msi_en), "msi_control_o");
      check_value(128'(msix_intfc), 128'(exp_cfg.msix_ctl), "msix_intfc_o");
      check_value(128'(dev_csr), 128'(exp_cfg.dev_csr), "dev_csr_o");
      check_value(128'(bus_dev), 128'(exp_cfg.bus_dev), "bus_dev_o");
      check_value(128'(rd_valid), 128'(exp_mux.valid), "txs_rd_valid_o");
      check_value(128'(rd_data), 128'(exp_mux.data), "txs_rd_data_o");
      check_value(128'(rxm_wait), 128'(exp_mux.wait_req), "rxm_wait_o");
   end

   initial
   begin
      #(STIM_CYCLES * 10 + 500);
      $display("TB FAILED");
      $fatal(1, "watchdog timeout, stimulus did not finish in time");
   end

endmodule

//--- pcie_cfg_bridge.f
+incdir+verif
src/cfg_bridge_pkg.sv
src/cfg_shadow.sv
src/msi_cfg_out.sv
src/rxm_rdata_mux.sv
src/pcie_cfg_bridge.sv
verif/tb_pcie_cfg_bridge.sv

//--- Makefile
# Verilator build and run of the bridge testbench
TOP = tb_pcie_cfg_bridge

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -Wno-fatal -f pcie_cfg_bridge.f \
		--top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb

lint:
	verilator --lint-only --timing -Wall -f pcie_cfg_bridge.f \
		--top-module pcie_cfg_bridge

clean:
	rm -rf obj_dir
